//--- hdl/mem_pkg.sv
package mem_pkg;

  localparam int WIDTH   = 16;
  localparam int NUMVBNK = 4;
  localparam int NUMPBNK = NUMVBNK + 1;      // One spare bank per row
  localparam int NUMVROW = 16;
  localparam int NUMWRDS = 2;
  localparam int NUMSROW = NUMVROW / NUMWRDS;

  typedef logic [WIDTH-1:0] data_t;

  typedef logic [$clog2(NUMVBNK)-1:0] vbank_t;

  typedef logic [$clog2(NUMPBNK)-1:0] pbank_t;

  typedef logic [$clog2(NUMVROW)-1:0] vrow_t;

  typedef logic [$clog2(NUMSROW)-1:0] srow_t;

  typedef logic [$clog2(NUMWRDS)-1:0] word_t;

  // Wide row of a physical bank
  typedef logic [NUMWRDS*WIDTH-1:0] phys_t;

  // Bank index sits above the row
  typedef logic [$bits(vbank_t)+$bits(vrow_t)-1:0] addr_t;

endpackage

//--- hdl/sp_bank.sv
`timescale 1ns/1ps

module sp_bank
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rd,
  input  logic  wr,
  input  srow_t row,
  input  phys_t bwe,
  input  phys_t wdata,
  output phys_t rdata
);

  phys_t mem [NUMSROW];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[row] <= (mem[row] & ~bwe) | (wdata & bwe);  // Masked bits only
    end
    if (rd) begin
      rdata <= mem[row];
    end
  end

  // Single port, the map must never steer two commands here
  a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd && wr));

endmodule

//--- hdl/bank_align.sv
`timescale 1ns/1ps

module bank_align
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rd,
  input  logic  wr,
  input  vrow_t vrow,
  input  data_t din,
  output data_t dout
);

  srow_t srow;
  word_t word;
  word_t word_q;
  phys_t bwe;
  phys_t wdata;
  phys_t rdata;

  assign srow = srow_t'(vrow / NUMWRDS);
  assign word = word_t'(vrow % NUMWRDS);

  // Lane mask for the addressed word
  assign bwe   = phys_t'({WIDTH{1'b1}}) << (word * WIDTH);
  assign wdata = {NUMWRDS{din}};

  sp_bank u_bank (
    .clk   (clk),
    .rst_n (rst_n),
    .rd    (rd),
    .wr    (wr),
    .row   (srow),
    .bwe   (bwe),
    .wdata (wdata),
    .rdata (rdata)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_q <= '0;
    end else if (rd) begin
      word_q <= word;  // Aligns with rdata
    end
  end

  assign dout = rdata[word_q*WIDTH +: WIDTH];

endmodule

//--- hdl/bank_map.sv
`timescale 1ns/1ps

module bank_map
  import mem_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  vbank_t vb0,
  input  vbank_t vb1,
  input  vrow_t  row0,
  input  vrow_t  row1,
  input  logic   act0,
  input  logic   act1,
  output pbank_t pb0,
  output pbank_t pb1,
  output logic   init_done
);

  localparam int FREE = NUMVBNK;  // Slot of the free bank

  pbank_t map [NUMVROW][NUMPBNK];
  vrow_t  init_row;
  pbank_t pb1_raw;
  pbank_t free1;
  logic   swap;
  logic [2**$bits(pbank_t)-1:0] seen1;

  assign pb0     = map[row0][vb0];
  assign pb1_raw = map[row1][vb1];
  assign free1   = map[row1][FREE];

  // Port 1 moves aside on a physical bank clash
  assign swap = init_done && act0 && act1 && (pb0 == pb1_raw);
  assign pb1  = swap ? free1 : pb1_raw;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      init_row  <= '0;
      init_done <= 1'b0;
    end else if (!init_done) begin
      init_row  <= init_row + 1'b1;
      init_done <= (init_row == vrow_t'(NUMVROW - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (!init_done) begin
      for (int i = 0; i < NUMPBNK; i++) begin
        map[init_row][i] <= pbank_t'(i);  // Identity, last bank free
      end
    end else if (swap) begin
      map[row1][vb1]  <= free1;
      map[row1][FREE] <= pb1_raw;
    end
  end

  // One hot per physical bank found in the row
  always_comb begin
    seen1 = '0;
    for (int i = 0; i < NUMPBNK; i++) begin
      seen1[map[row1][i]] = 1'b1;
    end
  end

  // Every earlier swap on this row kept it a permutation
  a_row_perm: assert property (@(posedge clk) disable iff (!rst_n)
    init_done && act1 |-> seen1 == ((1 << NUMPBNK) - 1));

endmodule

//--- hdl/refresh_sched.sv
`timescale 1ns/1ps

module refresh_sched
  import mem_pkg::*;
#(
  parameter int NUMRROW = 8,
  localparam int BITRROW = (NUMRROW > 1) ? $clog2(NUMRROW) : 1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               refr,
  input  logic               ready,
  output logic               refr_vld,
  output pbank_t             refr_bank,
  output logic [BITRROW-1:0] refr_row
);

  typedef logic [BITRROW-1:0] rrow_t;

  pbank_t bank_cnt;
  rrow_t  row_cnt;
  logic   take;

  assign take = refr && ready;  // Early pulses are dropped

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_cnt  <= '0;
      row_cnt   <= '0;
      refr_vld  <= 1'b0;
      refr_bank <= '0;
      refr_row  <= '0;
    end else begin
      refr_vld <= take;
      if (take) begin
        refr_bank <= bank_cnt;
        refr_row  <= row_cnt;
        if (bank_cnt == pbank_t'(NUMPBNK - 1)) begin
          bank_cnt <= '0;
          row_cnt  <= (row_cnt == rrow_t'(NUMRROW - 1)) ? '0 : row_cnt + 1'b1;  // Next row on wrap
        end else begin
          bank_cnt <= bank_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/mem_1rw1w_core.sv
`timescale 1ns/1ps

module mem_1rw1w_core
  import mem_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rd0,
  input  logic               wr0,
  input  logic               wr1,
  input  logic               refr,
  input  addr_t              addr0,
  input  addr_t              addr1,
  input  data_t              din0,
  input  data_t              din1,
  output logic               ready,
  output logic               rd_vld,
  output data_t              rd_dout,
  output logic [NUMPBNK-1:0] bk_rd,
  output logic [NUMPBNK-1:0] bk_wr,
  output vrow_t              bk_row [NUMPBNK],
  output data_t              bk_din [NUMPBNK],
  input  data_t              bk_dout [NUMPBNK]
);

  vbank_t vb0;
  vbank_t vb1;
  vrow_t  row0;
  vrow_t  row1;
  logic   rd0_g;
  logic   wr0_g;
  logic   wr1_g;
  logic   act0;
  logic   act1;
  pbank_t pb0;
  pbank_t pb1;
  logic   init_done;
  logic   rd_v1;
  pbank_t rd_bk1;

  assign vb0  = vbank_t'(addr0 >> $bits(vrow_t));
  assign row0 = vrow_t'(addr0);
  assign vb1  = vbank_t'(addr1 >> $bits(vrow_t));
  assign row1 = vrow_t'(addr1);

  assign rd0_g = rd0 && ready;
  assign wr0_g = wr0 && ready && !(wr1 && (addr0 == addr1));  // Port 1 wins
  assign wr1_g = wr1 && ready;
  assign act0  = rd0_g || wr0_g;
  assign act1  = wr1_g;

  bank_map u_map (
    .clk       (clk),
    .rst_n     (rst_n),
    .vb0       (vb0),
    .vb1       (vb1),
    .row0      (row0),
    .row1      (row1),
    .act0      (act0),
    .act1      (act1),
    .pb0       (pb0),
    .pb1       (pb1),
    .init_done (init_done)
  );

  always_comb begin
    bk_rd = '0;
    bk_wr = '0;
    for (int i = 0; i < NUMPBNK; i++) begin
      bk_row[i] = row0;
      bk_din[i] = din0;
      if (act1 && (pb1 == pbank_t'(i))) begin
        bk_wr[i]  = 1'b1;
        bk_row[i] = row1;
        bk_din[i] = din1;
      end else if (act0 && (pb0 == pbank_t'(i))) begin
        bk_rd[i] = rd0_g;
        bk_wr[i] = wr0_g;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready  <= 1'b0;
      rd_v1  <= 1'b0;
      rd_vld <= 1'b0;
    end else begin
      ready  <= init_done;
      rd_v1  <= rd0_g;
      rd_vld <= rd_v1;
    end
  end

  always_ff @(posedge clk) begin
    rd_bk1 <= pb0;  // Bank holding the read in flight
    if (rd_v1) begin
      rd_dout <= bk_dout[rd_bk1];
    end
  end

  a_port0_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd0 && wr0));

  a_refr_idle: assert property (@(posedge clk) disable iff (!rst_n)
    refr |-> !(rd0 || wr0 || wr1));

endmodule

//--- hdl/mem_1rw1w_top.sv
`timescale 1ns/1ps

module mem_1rw1w_top
  import mem_pkg::*;
#(
  parameter int NUMRROW = 8,
  localparam int BITRROW = (NUMRROW > 1) ? $clog2(NUMRROW) : 1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rd0,
  input  logic               wr0,
  input  logic               wr1,
  input  logic               refr,
  input  addr_t              addr0,
  input  addr_t              addr1,
  input  data_t              din0,
  input  data_t              din1,
  output logic               ready,
  output logic               rd_vld,
  output logic               refr_vld,
  output data_t              rd_dout,
  output pbank_t             refr_bank,
  output logic [BITRROW-1:0] refr_row
);

  logic [NUMPBNK-1:0] bk_rd;
  logic [NUMPBNK-1:0] bk_wr;
  vrow_t              bk_row [NUMPBNK];
  data_t              bk_din [NUMPBNK];
  data_t              bk_dout [NUMPBNK];

  mem_1rw1w_core u_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd0     (rd0),
    .wr0     (wr0),
    .wr1     (wr1),
    .refr    (refr),
    .addr0   (addr0),
    .addr1   (addr1),
    .din0    (din0),
    .din1    (din1),
    .ready   (ready),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .bk_rd   (bk_rd),
    .bk_wr   (bk_wr),
    .bk_row  (bk_row),
    .bk_din  (bk_din),
    .bk_dout (bk_dout)
  );

  for (genvar i = 0; i < NUMPBNK; i++) begin : g_bank
    bank_align u_align (
      .clk   (clk),
      .rst_n (rst_n),
      .rd    (bk_rd[i]),
      .wr    (bk_wr[i]),
      .vrow  (bk_row[i]),
      .din   (bk_din[i]),
      .dout  (bk_dout[i])
    );
  end

  refresh_sched #(
    .NUMRROW (NUMRROW)
  ) u_refr (
    .clk       (clk),
    .rst_n     (rst_n),
    .refr      (refr),
    .ready     (ready),
    .refr_vld  (refr_vld),
    .refr_bank (refr_bank),
    .refr_row  (refr_row)
  );

endmodule

//--- tb/tb_mem_1rw1w.sv
`timescale 1ns/1ps

module tb_mem_1rw1w
  import mem_pkg::*;
();

  localparam int NUMRROW = 8;
  localparam int RBITS   = (NUMRROW > 1) ? $clog2(NUMRROW) : 1;
  localparam int NUMADDR = NUMVBNK * NUMVROW;

  logic             clk;
  logic             rst_n;
  logic             rd0;
  logic             wr0;
  logic             wr1;
  logic             refr;
  addr_t            addr0;
  addr_t            addr1;
  data_t            din0;
  data_t            din1;
  logic             ready;
  logic             rd_vld;
  logic             refr_vld;
  data_t            rd_dout;
  pbank_t           refr_bank;
  logic [RBITS-1:0] refr_row;

  logic [31:0] lfsr = 32'h06a6_3e46;
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed = 0;
  data_t       shadow [NUMADDR];
  logic        written [NUMADDR];
  data_t       rd_q [$];
  int          rd_cyc_q [$];
  int          refr_cyc_q [$];
  int          model_bank = 0;
  int          model_row = 0;

  mem_1rw1w_top #(
    .NUMRROW (NUMRROW)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd0       (rd0),
    .wr0       (wr0),
    .wr1       (wr1),
    .refr      (refr),
    .addr0     (addr0),
    .addr1     (addr1),
    .din0      (din0),
    .din1      (din1),
    .ready     (ready),
    .rd_vld    (rd_vld),
    .refr_vld  (refr_vld),
    .rd_dout   (rd_dout),
    .refr_bank (refr_bank),
    .refr_row  (refr_row)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic drive(input logic r0, input logic w0, input addr_t a0, input data_t d0,
                       input logic w1, input addr_t a1, input data_t d1);
    @(posedge clk);
    rd0   <= r0;
    wr0   <= w0;
    addr0 <= a0;
    din0  <= d0;
    wr1   <= w1;
    addr1 <= a1;
    din1  <= d1;
    refr  <= 1'b0;
    if (r0) begin
      rd_q.push_back(shadow[a0]);  // Old data, before this cycle's writes
      rd_cyc_q.push_back(cyc + 3);  // rd_vld seen one edge after it rises
    end
    if (w0 && !(w1 && (a0 == a1))) begin
      shadow[a0]  = d0;
      written[a0] = 1'b1;
    end
    if (w1) begin
      shadow[a1]  = d1;
      written[a1] = 1'b1;
    end
  endtask

  task automatic idle();
    drive(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  task automatic refresh_pulse();
    @(posedge clk);
    refr <= 1'b1;
    refr_cyc_q.push_back(cyc + 2);
    idle();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((rd_q.size() != 0 || refr_cyc_q.size() != 0) && n < 20) begin
      idle();
      n++;
    end
    if (rd_q.size() != 0 || refr_cyc_q.size() != 0) begin
      errors++;
      $display("Timeout at %0t with %0d reads and %0d refresh commands outstanding",
               $time, rd_q.size(), refr_cyc_q.size());
      rd_q.delete();
      rd_cyc_q.delete();
      refr_cyc_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    tests++;
    if (errors == err_start) begin
      $display("test %0d %s: passed", tests, name);
    end else begin
      failed++;
      $display("test %0d %s: failed with %0d errors", tests, name, errors - err_start);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && rd_vld) begin
      checks++;
      if (rd_q.size() == 0) begin
        errors++;
        $display("Read data returned at %0t with no read in flight", $time);
      end else begin
        a_rd_data: assert (rd_dout == rd_q[0]) else begin
          errors++;
          $display("Fail %0t rd_dout got %h expected %h", $time, rd_dout, rd_q[0]);
        end
        a_rd_time: assert (cyc == rd_cyc_q[0]) else begin
          errors++;
          $display("Fail %0t rd_vld cycle got %0d expected %0d", $time, cyc, rd_cyc_q[0]);
        end
        void'(rd_q.pop_front());
        void'(rd_cyc_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && refr_vld) begin
      checks++;
      if (refr_cyc_q.size() == 0) begin
        errors++;
        $display("Refresh command at %0t without an accepted pulse", $time);
      end else begin
        a_refr_bank: assert (int'(refr_bank) == model_bank) else begin
          errors++;
          $display("Fail %0t refr_bank got %0d expected %0d", $time, refr_bank, model_bank);
        end
        a_refr_row: assert (int'(refr_row) == model_row) else begin
          errors++;
          $display("Fail %0t refr_row got %0d expected %0d", $time, refr_row, model_row);
        end
        a_refr_time: assert (cyc == refr_cyc_q[0]) else begin
          errors++;
          $display("Fail %0t refr_vld cycle got %0d expected %0d", $time, cyc, refr_cyc_q[0]);
        end
        void'(refr_cyc_q.pop_front());
      end
      if (model_bank == NUMPBNK - 1) begin
        model_bank = 0;
        model_row  = (model_row + 1) % NUMRROW;  // Row steps on bank wrap
      end else begin
        model_bank = model_bank + 1;
      end
    end
  end

  a_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n) ready |=> ready)
    else begin
      errors++;
      $display("Fail %0t ready got %b expected 1", $time, ready);
    end

  a_quiet_before_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !ready |-> !rd_vld && !refr_vld)
    else begin
      errors++;
      $display("Read or refresh strobe at %0t while ready is low", $time);
    end

  initial begin
    int    err0;
    int    n;
    addr_t a;
    addr_t b;
    data_t d;
    data_t e;
    logic [1:0] op;
    rst_n = 1'b0;
    rd0   = 1'b0;
    wr0   = 1'b0;
    wr1   = 1'b0;
    refr  = 1'b0;
    addr0 = '0;
    addr1 = '0;
    din0  = '0;
    din1  = '0;
    for (int i = 0; i < NUMADDR; i++) begin
      written[i] = 1'b0;
    end

    err0 = errors;
    repeat (10) @(posedge clk);
    checks++;
    a_reset_quiet: assert (!ready && !rd_vld && !refr_vld) else begin
      errors++;
      $display("Fail %0t ready,rd_vld,refr_vld got %b%b%b expected 000",
               $time, ready, rd_vld, refr_vld);
    end
    rst_n <= 1'b1;
    n = 0;
    while (!ready && n < 40) begin
      @(posedge clk);
      n++;
      refr <= (n == 3 || n == 8);  // Early pulses, dropped
    end
    checks++;
    if (!ready) begin
      errors++;
      $display("ready did not rise within %0d cycles of reset release", n);
    end else begin
      a_ready_time: assert (n - 1 == NUMVROW + 1) else begin  // Rose one edge earlier
        errors++;
        $display("Fail %0t ready rise cycle got %0d expected %0d", $time, n - 1, NUMVROW + 1);
      end
    end
    end_test("reset and ready", err0);

    err0 = errors;
    drive(1'b0, 1'b1, 6'h05, 16'h1234, 1'b0, '0, '0);
    drive(1'b1, 1'b0, 6'h05, '0, 1'b0, '0, '0);
    drive(1'b0, 1'b1, 6'h24, 16'habcd, 1'b0, '0, '0);
    drive(1'b0, 1'b1, 6'h25, 16'h5a5a, 1'b0, '0, '0);  // Same physical row
    drive(1'b1, 1'b0, 6'h24, '0, 1'b0, '0, '0);
    drive(1'b1, 1'b0, 6'h25, '0, 1'b0, '0, '0);
    drive(1'b1, 1'b0, 6'h05, '0, 1'b0, '0, '0);
    drain();
    end_test("write then read", err0);

    err0 = errors;
    drive(1'b0, 1'b1, 6'h13, 16'h1111, 1'b0, '0, '0);
    drive(1'b0, 1'b1, 6'h18, 16'h3333, 1'b0, '0, '0);
    drive(1'b1, 1'b0, 6'h13, '0, 1'b1, 6'h18, 16'h4444);  // Other row, same bank
    drive(1'b1, 1'b0, 6'h13, '0, 1'b1, 6'h13, 16'h2222);
    drive(1'b1, 1'b0, 6'h18, '0, 1'b0, '0, '0);
    drive(1'b1, 1'b0, 6'h13, '0, 1'b0, '0, '0);
    drain();
    end_test("read during port 1 write", err0);

    err0 = errors;
    drive(1'b0, 1'b1, 6'h2a, 16'haaaa, 1'b1, 6'h2a, 16'hbbbb);
    drive(1'b1, 1'b0, 6'h2a, '0, 1'b0, '0, '0);
    drain();
    end_test("same address writes", err0);

    err0 = errors;
    repeat (300) begin
      op = rand_bits(2);
      a  = addr_t'(rand_bits(6) & 32'h37);  // Rows 0 to 7
      if (rand_bits(1) != 0) begin
        b = a;
      end else begin
        b = addr_t'(rand_bits(6) & 32'h37);
      end
      d = data_t'(rand_bits(16));
      e = data_t'(rand_bits(16));
      drive((op == 2'd1) && written[a], op[1], a, d, rand_bits(1) != 0, b, e);
    end
    drain();
    end_test("random stress", err0);

    err0 = errors;
    repeat (NUMPBNK * NUMRROW + 3) begin
      refresh_pulse();
    end
    drain();
    end_test("refresh order", err0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/mem_pkg.sv
hdl/sp_bank.sv
hdl/bank_align.sv
hdl/bank_map.sv
hdl/refresh_sched.sv
hdl/mem_1rw1w_core.sv
hdl/mem_1rw1w_top.sv
tb/tb_mem_1rw1w.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_1rw1w -f sim.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  exit 0
else
  exit 1
fi
